// ==== hdl/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// Datapath, register address and field widths
	localparam int DATA_W = 16;
	localparam int REG_AW = 4;
	localparam int OP_W = 4;
	localparam int IMM_W = 8;

	// Opcodes, codes 1 and 7 unused
	localparam logic [OP_W-1:0] OP_ADD  = 4'h0;
	localparam logic [OP_W-1:0] OP_SUB  = 4'h2;
	localparam logic [OP_W-1:0] OP_AND  = 4'h3;
	localparam logic [OP_W-1:0] OP_NOR  = 4'h4;
	localparam logic [OP_W-1:0] OP_SLL  = 4'h5;
	localparam logic [OP_W-1:0] OP_SRL  = 4'h6;
	localparam logic [OP_W-1:0] OP_LW   = 4'h8;
	localparam logic [OP_W-1:0] OP_SW   = 4'h9;
	localparam logic [OP_W-1:0] OP_LHB  = 4'hA;
	localparam logic [OP_W-1:0] OP_LLB  = 4'hB;
	localparam logic [OP_W-1:0] OP_BEQZ = 4'hC;
	localparam logic [OP_W-1:0] OP_BNEZ = 4'hD;
	localparam logic [OP_W-1:0] OP_JR   = 4'hE;
	localparam logic [OP_W-1:0] OP_HLT  = 4'hF;

	// One instruction word, two decodings
	typedef union packed {
		struct packed {
			logic [OP_W-1:0]   op;
			logic [REG_AW-1:0] rd;
			logic [REG_AW-1:0] rs;
			logic [REG_AW-1:0] rt;
		} r_form;
		struct packed {
			logic [OP_W-1:0]   op;
			logic [REG_AW-1:0] rd;
			logic [IMM_W-1:0]  imm8;
		} i_form;
	} instr_t;

	// Second source register
	// Store data, LHB and branches read rd in place of rt
	function automatic logic [REG_AW-1:0] src_b(input instr_t i);
		case (i.r_form.op)
			OP_SW, OP_LHB, OP_BEQZ, OP_BNEZ: return i.r_form.rd;
			default: return i.r_form.rt;
		endcase
	endfunction

	// Does the instruction really read rs
	function automatic logic reads_a(input instr_t i);
		return !(i.r_form.op inside {OP_LLB, OP_LHB, OP_BEQZ, OP_BNEZ, OP_HLT});
	endfunction

	// Does it read the second source
	function automatic logic reads_b(input instr_t i);
		return i.r_form.op inside {OP_ADD, OP_SUB, OP_AND, OP_NOR,
			OP_SW, OP_LHB, OP_BEQZ, OP_BNEZ};
	endfunction

endpackage

// ==== hdl/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	// Operand forwarding selects
	localparam int FWD_W = 2;

	// Register file value from decode
	localparam logic [FWD_W-1:0] FWD_REG = 2'b00;
	// ALU result sitting in memory stage
	localparam logic [FWD_W-1:0] FWD_MEM = 2'b01;
	// Final write-back data
	localparam logic [FWD_W-1:0] FWD_WB  = 2'b10;

	// Write-back data selects
	localparam logic WB_ALU  = 1'b0;
	localparam logic WB_LOAD = 1'b1;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           freeze,
	input  logic                           stall_id,
	input  logic                           halt_seen,
	input  logic                           redirect,
	input  logic [cpu_isa_pkg::DATA_W-1:0] redirect_pc,
	output logic [cpu_isa_pkg::DATA_W-1:0] imem_addr,
	input  logic [cpu_isa_pkg::DATA_W-1:0] imem_data,
	output logic [cpu_isa_pkg::DATA_W-1:0] pc,
	output cpu_isa_pkg::instr_t            instr_id,
	output logic [cpu_isa_pkg::DATA_W-1:0] pc_id
);

	logic [cpu_isa_pkg::DATA_W-1:0] pc_plus_1;

	assign pc_plus_1 = pc + 1'b1;
	// Instruction port reads the current pc directly
	assign imem_addr = pc;

	// Program counter
	// Redirect beats stall and halt, freeze beats everything
	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (!freeze) begin
			if (redirect)
				pc <= redirect_pc;
			else if (!stall_id && !halt_seen)
				pc <= pc_plus_1;
		end
	end

	// Fetch/decode register
	// All-zero word is ADD r0, acts as the bubble
	always_ff @(posedge clk) begin
		if (!rst_n)
			instr_id <= '0;
		else if (!freeze) begin
			if (redirect)
				instr_id <= '0;
			else if (!stall_id)
				instr_id <= halt_seen ? '0 : imem_data;
		end
	end

	// Next pc travels along for branch targets
	always_ff @(posedge clk) begin
		if (!freeze && !stall_id)
			pc_id <= pc_plus_1;
	end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           freeze,
	input  logic                           stall_id,
	input  logic                           flush,
	input  cpu_isa_pkg::instr_t            instr_id,
	input  logic [cpu_isa_pkg::DATA_W-1:0] pc_id,
	input  logic                           wb_we_rf,
	input  logic [cpu_isa_pkg::REG_AW-1:0] wb_rd,
	input  logic [cpu_isa_pkg::DATA_W-1:0] wb_data,
	output logic [cpu_isa_pkg::DATA_W-1:0] p0,
	output logic [cpu_isa_pkg::DATA_W-1:0] p1,
	output logic [cpu_isa_pkg::DATA_W-1:0] imm,
	output logic [cpu_isa_pkg::REG_AW-1:0] rd_ex,
	output cpu_isa_pkg::instr_t            instr_ex,
	output logic [cpu_isa_pkg::DATA_W-1:0] pc_ex,
	output logic [cpu_isa_pkg::OP_W-1:0]   alu_op,
	output logic                           we_rf_ex,
	output logic                           mem_rd_ex,
	output logic                           mem_wr_ex,
	output logic                           halt_seen,
	output logic                           halt_ex
);

	logic [cpu_isa_pkg::DATA_W-1:0] regs [0:(1 << cpu_isa_pkg::REG_AW)-1];
	logic [cpu_isa_pkg::DATA_W-1:0] rf_a, rf_b, imm_d, rt_ext, imm8_ext;
	logic [cpu_isa_pkg::REG_AW-1:0] rb;
	logic [cpu_isa_pkg::OP_W-1:0] op, alu_op_d;
	logic we_rf_d, halt_q;

	assign op = instr_id.r_form.op;
	assign rb = cpu_isa_pkg::src_b(instr_id);

	////////////////////////////////////////////////////////////////////////////
	// Register file

	// Write on the edge
	always_ff @(posedge clk) begin
		if (wb_we_rf)
			regs[wb_rd] <= wb_data;
	end

	// Read ports, r0 hardwired, same-cycle write bypassed
	function automatic logic [cpu_isa_pkg::DATA_W-1:0] rf_read(
		input logic [cpu_isa_pkg::REG_AW-1:0] ra
	);
		if (ra == '0)
			return '0;
		else if (wb_we_rf && wb_rd == ra)
			return wb_data;
		else
			return regs[ra];
	endfunction

	always_comb begin
		rf_a = rf_read(instr_id.r_form.rs);
		rf_b = rf_read(rb);
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction decode

	assign rt_ext = {{(cpu_isa_pkg::DATA_W-cpu_isa_pkg::REG_AW){1'b0}}, instr_id.r_form.rt};
	assign imm8_ext = {{(cpu_isa_pkg::DATA_W-cpu_isa_pkg::IMM_W){instr_id.i_form.imm8[7]}},
		instr_id.i_form.imm8};

	// Memory ops share one address add
	always_comb begin
		imm_d = imm8_ext;
		alu_op_d = op;
		case (op)
			cpu_isa_pkg::OP_LW, cpu_isa_pkg::OP_SW: begin
				imm_d = rt_ext;
				alu_op_d = cpu_isa_pkg::OP_LW;
			end
			cpu_isa_pkg::OP_SLL, cpu_isa_pkg::OP_SRL:
				imm_d = rt_ext;
			default: ;
		endcase
	end

	// Writes to r0 are dropped here, so bubbles need no valid bit
	assign we_rf_d = (instr_id.r_form.rd != '0) && (op inside {cpu_isa_pkg::OP_ADD,
		cpu_isa_pkg::OP_SUB, cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_NOR, cpu_isa_pkg::OP_SLL,
		cpu_isa_pkg::OP_SRL, cpu_isa_pkg::OP_LLB, cpu_isa_pkg::OP_LHB, cpu_isa_pkg::OP_LW});

	// HLT in decode stops fetch now and for good once it moves on
	assign halt_seen = halt_q || (op == cpu_isa_pkg::OP_HLT);

	////////////////////////////////////////////////////////////////////////////
	// Decode/execute register

	// Controls, cleared on flush or load-use stall
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr_ex <= '0;
			we_rf_ex <= 1'b0;
			mem_rd_ex <= 1'b0;
			mem_wr_ex <= 1'b0;
			halt_ex <= 1'b0;
			halt_q <= 1'b0;
		end else if (!freeze) begin
			if (flush || stall_id) begin
				instr_ex <= '0;
				we_rf_ex <= 1'b0;
				mem_rd_ex <= 1'b0;
				mem_wr_ex <= 1'b0;
				halt_ex <= 1'b0;
			end else begin
				instr_ex <= instr_id;
				we_rf_ex <= we_rf_d;
				mem_rd_ex <= (op == cpu_isa_pkg::OP_LW);
				mem_wr_ex <= (op == cpu_isa_pkg::OP_SW);
				halt_ex <= (op == cpu_isa_pkg::OP_HLT);
				if (op == cpu_isa_pkg::OP_HLT)
					halt_q <= 1'b1;
			end
		end
	end

	// Operands and immediates
	always_ff @(posedge clk) begin
		if (!freeze) begin
			p0 <= rf_a;
			p1 <= rf_b;
			imm <= imm_d;
			rd_ex <= instr_id.r_form.rd;
			pc_ex <= pc_id;
			alu_op <= alu_op_d;
		end
	end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            freeze,
	input  logic [cpu_ctrl_pkg::FWD_W-1:0]  fwd_a,
	input  logic [cpu_ctrl_pkg::FWD_W-1:0]  fwd_b,
	input  logic [cpu_isa_pkg::DATA_W-1:0]  mem_result,
	input  logic [cpu_isa_pkg::DATA_W-1:0]  wb_data,
	input  logic [cpu_isa_pkg::DATA_W-1:0]  p0,
	input  logic [cpu_isa_pkg::DATA_W-1:0]  p1,
	input  logic [cpu_isa_pkg::DATA_W-1:0]  imm,
	input  logic [cpu_isa_pkg::REG_AW-1:0]  rd_ex,
	input  cpu_isa_pkg::instr_t             instr_ex,
	input  logic [cpu_isa_pkg::DATA_W-1:0]  pc_ex,
	input  logic [cpu_isa_pkg::OP_W-1:0]    alu_op,
	input  logic                            we_rf_ex,
	input  logic                            mem_rd_ex,
	input  logic                            mem_wr_ex,
	input  logic                            halt_ex,
	output logic [cpu_isa_pkg::DATA_W-1:0]  result_mem,
	output logic [cpu_isa_pkg::DATA_W-1:0]  sdata_mem,
	output logic [cpu_isa_pkg::REG_AW-1:0]  rd_mem,
	output logic                            we_rf_mem,
	output logic                            mem_rd,
	output logic                            mem_wr,
	output logic                            halt_mem,
	output logic                            redirect,
	output logic [cpu_isa_pkg::DATA_W-1:0]  redirect_pc
);

	logic [cpu_isa_pkg::DATA_W-1:0] a, b, result;
	logic [cpu_isa_pkg::OP_W-1:0] op;

	// Operand source mux
	function automatic logic [cpu_isa_pkg::DATA_W-1:0] fwd_mux(
		input logic [cpu_ctrl_pkg::FWD_W-1:0]  sel,
		input logic [cpu_isa_pkg::DATA_W-1:0]  rf,
		input logic [cpu_isa_pkg::DATA_W-1:0]  from_mem,
		input logic [cpu_isa_pkg::DATA_W-1:0]  from_wb
	);
		case (sel)
			cpu_ctrl_pkg::FWD_MEM: return from_mem;
			cpu_ctrl_pkg::FWD_WB: return from_wb;
			default: return rf;
		endcase
	endfunction

	assign a = fwd_mux(fwd_a, p0, mem_result, wb_data);
	assign b = fwd_mux(fwd_b, p1, mem_result, wb_data);
	assign op = instr_ex.r_form.op;

	// ALU and shifter
	// Shift amount sits in the low bits of imm
	always_comb begin
		case (alu_op)
			cpu_isa_pkg::OP_ADD: result = a + b;
			cpu_isa_pkg::OP_SUB: result = a - b;
			cpu_isa_pkg::OP_AND: result = a & b;
			cpu_isa_pkg::OP_NOR: result = ~(a | b);
			cpu_isa_pkg::OP_SLL: result = a << imm[cpu_isa_pkg::REG_AW-1:0];
			cpu_isa_pkg::OP_SRL: result = a >> imm[cpu_isa_pkg::REG_AW-1:0];
			cpu_isa_pkg::OP_LLB: result = imm;
			// Upper byte from imm, lower kept from rd
			cpu_isa_pkg::OP_LHB: result = {imm[cpu_isa_pkg::IMM_W-1:0],
				b[cpu_isa_pkg::DATA_W-cpu_isa_pkg::IMM_W-1:0]};
			// Load and store address
			cpu_isa_pkg::OP_LW: result = a + imm;
			default: result = a;
		endcase
	end

	// Branches test rd, which arrives on b
	assign redirect = (op == cpu_isa_pkg::OP_JR) ||
		(op == cpu_isa_pkg::OP_BEQZ && b == '0) ||
		(op == cpu_isa_pkg::OP_BNEZ && b != '0);
	assign redirect_pc = (op == cpu_isa_pkg::OP_JR) ? a : pc_ex + imm;

	// Execute/memory register, controls
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			we_rf_mem <= 1'b0;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
			halt_mem <= 1'b0;
		end else if (!freeze) begin
			we_rf_mem <= we_rf_ex;
			mem_rd <= mem_rd_ex;
			mem_wr <= mem_wr_ex;
			halt_mem <= halt_ex;
		end
	end

	// Result, store data from rd, destination
	always_ff @(posedge clk) begin
		if (!freeze) begin
			result_mem <= result;
			sdata_mem <= b;
			rd_mem <= rd_ex;
		end
	end

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_isa_pkg::DATA_W-1:0] result_mem,
	input  logic [cpu_isa_pkg::DATA_W-1:0] sdata_mem,
	input  logic [cpu_isa_pkg::REG_AW-1:0] rd_mem,
	input  logic                           we_rf_mem,
	input  logic                           mem_rd,
	input  logic                           mem_wr,
	input  logic                           halt_mem,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [cpu_isa_pkg::DATA_W-1:0] wb_adr,
	output logic [cpu_isa_pkg::DATA_W-1:0] wb_dat_o,
	input  logic [cpu_isa_pkg::DATA_W-1:0] wb_dat_i,
	input  logic                           wb_ack,
	output logic                           bus_busy,
	output logic [cpu_isa_pkg::DATA_W-1:0] mem_result,
	output logic                           wb_we_rf,
	output logic [cpu_isa_pkg::REG_AW-1:0] wb_rd,
	output logic [cpu_isa_pkg::DATA_W-1:0] wb_data,
	output logic                           hlt
);

	logic acc_done, wb_sel, halt_wb;
	logic [cpu_isa_pkg::DATA_W-1:0] ldata, alu_wb, load_wb;

	// Wishbone classic master
	// Cycle opens as a memory op enters and closes after ack
	assign wb_cyc = (mem_rd || mem_wr) && !acc_done;
	assign wb_stb = wb_cyc;
	assign wb_we = wb_cyc && mem_wr;
	assign wb_adr = result_mem;
	assign wb_dat_o = sdata_mem;

	// Whole pipeline waits while the cycle is open
	assign bus_busy = wb_cyc;
	// ALU result is the only forwardable value here
	assign mem_result = result_mem;

	// Access finished, held through the idle cycle after ack
	always_ff @(posedge clk) begin
		if (!rst_n)
			acc_done <= 1'b0;
		else if (wb_cyc && wb_ack)
			acc_done <= 1'b1;
		else if (!wb_cyc)
			acc_done <= 1'b0;
	end

	// Load data capture
	always_ff @(posedge clk) begin
		if (wb_cyc && wb_ack && !mem_wr)
			ldata <= wb_dat_i;
	end

	// Memory/write-back register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_we_rf <= 1'b0;
			wb_sel <= cpu_ctrl_pkg::WB_ALU;
			halt_wb <= 1'b0;
		end else if (!bus_busy) begin
			wb_we_rf <= we_rf_mem;
			wb_sel <= mem_rd ? cpu_ctrl_pkg::WB_LOAD : cpu_ctrl_pkg::WB_ALU;
			halt_wb <= halt_mem;
		end
	end

	// Loaded word moves on with its instruction, safe from the next load
	always_ff @(posedge clk) begin
		if (!bus_busy) begin
			alu_wb <= result_mem;
			load_wb <= ldata;
			wb_rd <= rd_mem;
		end
	end

	assign wb_data = (wb_sel == cpu_ctrl_pkg::WB_LOAD) ? load_wb : alu_wb;

	// Sticky halt, one cycle after HLT leaves write-back
	always_ff @(posedge clk) begin
		if (!rst_n)
			hlt <= 1'b0;
		else if (halt_wb)
			hlt <= 1'b1;
	end

endmodule

// ==== hdl/forward_unit.sv ====
`timescale 1ns/1ns

module forward_unit (
	input  cpu_isa_pkg::instr_t            instr_ex,
	input  logic                           we_rf_mem,
	input  logic [cpu_isa_pkg::REG_AW-1:0] rd_mem,
	input  logic                           wb_we_rf,
	input  logic [cpu_isa_pkg::REG_AW-1:0] wb_rd,
	output logic [cpu_ctrl_pkg::FWD_W-1:0] fwd_a,
	output logic [cpu_ctrl_pkg::FWD_W-1:0] fwd_b
);

	// Youngest producer wins, r0 never forwarded
	function automatic logic [cpu_ctrl_pkg::FWD_W-1:0] pick(
		input logic [cpu_isa_pkg::REG_AW-1:0] src
	);
		if (src == '0)
			return cpu_ctrl_pkg::FWD_REG;
		else if (we_rf_mem && rd_mem == src)
			return cpu_ctrl_pkg::FWD_MEM;
		else if (wb_we_rf && wb_rd == src)
			return cpu_ctrl_pkg::FWD_WB;
		else
			return cpu_ctrl_pkg::FWD_REG;
	endfunction

	always_comb begin
		fwd_a = pick(instr_ex.r_form.rs);
		// rt or rd, as decode chose
		fwd_b = pick(cpu_isa_pkg::src_b(instr_ex));
	end

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
	input  cpu_isa_pkg::instr_t            instr_id,
	input  logic                           mem_rd_ex,
	input  logic [cpu_isa_pkg::REG_AW-1:0] rd_ex,
	input  logic                           bus_busy,
	output logic                           stall_id,
	output logic                           freeze
);

	logic hit_a, hit_b;

	// Only sources the decode instruction really reads
	assign hit_a = cpu_isa_pkg::reads_a(instr_id) && (instr_id.r_form.rs == rd_ex);
	assign hit_b = cpu_isa_pkg::reads_b(instr_id) && (cpu_isa_pkg::src_b(instr_id) == rd_ex);

	// Load in execute, one stall cycle
	assign stall_id = mem_rd_ex && (rd_ex != '0) && (hit_a || hit_b);

	// Bus wait holds every stage
	assign freeze = bus_busy;

endmodule

// ==== hdl/cpu.sv ====
`timescale 1ns/1ns

module cpu #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic                           clk,
	input  logic                           rst_n,
	output logic [cpu_isa_pkg::DATA_W-1:0] imem_addr,
	input  logic [cpu_isa_pkg::DATA_W-1:0] imem_data,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [cpu_isa_pkg::DATA_W-1:0] wb_adr,
	output logic [cpu_isa_pkg::DATA_W-1:0] wb_dat_o,
	input  logic [cpu_isa_pkg::DATA_W-1:0] wb_dat_i,
	input  logic                           wb_ack,
	output logic [cpu_isa_pkg::DATA_W-1:0] pc,
	output logic                           hlt
);

	////////////////////////////////////////////////////////////////////////////
	// Stage to stage wires

	// Fetch to decode
	cpu_isa_pkg::instr_t instr_id;
	logic [cpu_isa_pkg::DATA_W-1:0] pc_id;

	// Decode to execute
	cpu_isa_pkg::instr_t instr_ex;
	logic [cpu_isa_pkg::DATA_W-1:0] p0, p1, imm, pc_ex;
	logic [cpu_isa_pkg::REG_AW-1:0] rd_ex;
	logic [cpu_isa_pkg::OP_W-1:0] alu_op;
	logic we_rf_ex, mem_rd_ex, mem_wr_ex, halt_ex, halt_seen;

	// Execute to memory, and the redirect back to fetch
	logic [cpu_isa_pkg::DATA_W-1:0] result_mem, sdata_mem, redirect_pc;
	logic [cpu_isa_pkg::REG_AW-1:0] rd_mem;
	logic we_rf_mem, mem_rd, mem_wr, halt_mem, redirect;

	// Write-back and forwarding
	logic [cpu_isa_pkg::DATA_W-1:0] mem_result, wb_data;
	logic [cpu_isa_pkg::REG_AW-1:0] wb_rd;
	logic wb_we_rf;
	logic [cpu_ctrl_pkg::FWD_W-1:0] fwd_a, fwd_b;

	// Pipeline control
	logic bus_busy, freeze, stall_id;

	////////////////////////////////////////////////////////////////////////////
	// Stages

	fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
		.clk, .rst_n, .freeze, .stall_id, .halt_seen, .redirect, .redirect_pc,
		.imem_addr, .imem_data, .pc, .instr_id, .pc_id
	);

	// Taken branch or JR flushes the decode slot
	decode_stage i_decode (
		.clk, .rst_n, .freeze, .stall_id, .flush(redirect),
		.instr_id, .pc_id, .wb_we_rf, .wb_rd, .wb_data,
		.p0, .p1, .imm, .rd_ex, .instr_ex, .pc_ex, .alu_op,
		.we_rf_ex, .mem_rd_ex, .mem_wr_ex, .halt_seen, .halt_ex
	);

	execute_stage i_execute (
		.clk, .rst_n, .freeze, .fwd_a, .fwd_b, .mem_result, .wb_data,
		.p0, .p1, .imm, .rd_ex, .instr_ex, .pc_ex, .alu_op,
		.we_rf_ex, .mem_rd_ex, .mem_wr_ex, .halt_ex,
		.result_mem, .sdata_mem, .rd_mem, .we_rf_mem, .mem_rd, .mem_wr,
		.halt_mem, .redirect, .redirect_pc
	);

	mem_stage i_mem (
		.clk, .rst_n, .result_mem, .sdata_mem, .rd_mem, .we_rf_mem,
		.mem_rd, .mem_wr, .halt_mem,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_dat_i, .wb_ack,
		.bus_busy, .mem_result, .wb_we_rf, .wb_rd, .wb_data, .hlt
	);

	////////////////////////////////////////////////////////////////////////////
	// Hazard handling

	forward_unit i_forward (
		.instr_ex, .we_rf_mem, .rd_mem, .wb_we_rf, .wb_rd, .fwd_a, .fwd_b
	);

	hazard_unit i_hazard (
		.instr_id, .mem_rd_ex, .rd_ex, .bus_busy, .stall_id, .freeze
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	// Free running, starts low
	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

	logic clk, rst_n, wb_cyc, wb_stb, wb_we, wb_ack, hlt;
	logic [cpu_isa_pkg::DATA_W-1:0] imem_addr, imem_data, wb_adr, wb_dat_o, wb_dat_i, pc;
	logic [15:0] cases [0:255];
	logic [15:0] imem [0:255];
	logic [15:0] dmem [0:255];
	logic [15:0] exp_adr [$];
	logic [15:0] exp_dat [$];
	int test_start [0:15];
	int num_tests, errors, failed_tests, cur_maxw, max_wait, total_instr, stores_seen;
	int limit_ns, waits_left;
	integer seed = 32'h0b24f3c1;
	logic s_cyc, s_stb, s_we, s_ack, s_rst, after_ack, held, in_acc, h_we;
	logic [15:0] s_adr, s_dat, h_adr, h_dat;

	tb_clock #(.PERIOD(100)) i_clock (.clk);

	cpu #(.RESET_PC(16'h0000)) i_cpu (
		.clk, .rst_n, .imem_addr, .imem_data, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
		.wb_dat_o, .wb_dat_i, .wb_ack, .pc, .hlt
	);

	// Instruction memory answers in the same cycle
	assign imem_data = imem[imem_addr[7:0]];

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks and failure notes

	task automatic note_failure(input string msg);
		$display("%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("error at %0t: %s got %b expected %b", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [cpu_isa_pkg::DATA_W-1:0] got,
		input logic [cpu_isa_pkg::DATA_W-1:0] want);
		if (got !== want) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_instr(input string name, input cpu_isa_pkg::instr_t got,
		input cpu_isa_pkg::instr_t want);
		if (got !== want) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	// Completed bus write against the next expected store
	task automatic record_store(input logic [15:0] adr, input logic [15:0] dat);
		stores_seen++;
		if (adr > 16'h00FF)
			note_failure($sformatf("store outside data memory at %h", adr));
		else
			dmem[adr[7:0]] = dat;
		if (exp_adr.size() == 0)
			note_failure($sformatf("unexpected store of %h to %h", dat, adr));
		else begin
			check_word("wb_adr", adr, exp_adr.pop_front());
			check_word("wb_dat_o", dat, exp_dat.pop_front());
		end
	endtask

	// Fill memories, then program, data and store list of one test
	task automatic load_test(input int t, output logic [15:0] exp_pc,
		output logic [15:0] exp_instr);
		int p, n, nd, ns, prog;
		p = test_start[t];
		cur_maxw = cases[p];
		n = cases[p + 1];
		p += 2;
		prog = p;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 16'hF000 | i;
			dmem[i] = i ^ 16'h5A5A;
		end
		for (int i = 0; i < n; i++)
			imem[i] = cases[p + i];
		p += n;
		nd = cases[p];
		for (int i = 0; i < nd; i++)
			dmem[cases[p + 1 + 2 * i]] = cases[p + 2 + 2 * i];
		p += 1 + 2 * nd;
		ns = cases[p];
		exp_adr.delete();
		exp_dat.delete();
		for (int i = 0; i < ns; i++) begin
			exp_adr.push_back(cases[p + 1 + 2 * i]);
			exp_dat.push_back(cases[p + 2 + 2 * i]);
		end
		exp_pc = cases[p + 1 + 2 * ns];
		// Word sitting at the stopped pc, program or fill
		if (exp_pc < n)
			exp_instr = cases[prog + exp_pc];
		else
			exp_instr = 16'hF000 | exp_pc[7:0];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Wishbone handshake monitor

	// Mid-cycle sample, master and slave sides both settled
	always begin
		@(negedge clk);
		s_cyc = wb_cyc;
		s_stb = wb_stb;
		s_we = wb_we;
		s_adr = wb_adr;
		s_dat = wb_dat_o;
		s_ack = wb_ack;
		s_rst = rst_n;
		if (s_rst === 1'b1) begin
			if (s_cyc !== s_stb)
				note_failure("wb_stb does not follow wb_cyc");
			if (after_ack && s_cyc !== 1'b0)
				note_failure("wb_cyc still high in the cycle after ack");
			if (held && (s_cyc !== 1'b1 || s_we !== h_we || s_adr !== h_adr || s_dat !== h_dat))
				note_failure("Wishbone signals changed before ack");
			after_ack = s_cyc && s_ack;
			held = s_cyc && !s_ack;
			h_we = s_we;
			h_adr = s_adr;
			h_dat = s_dat;
			if (s_cyc && s_ack && s_we)
				record_store(s_adr, s_dat);
		end else begin
			after_ack = 1'b0;
			held = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Wishbone slave with wait states

	// Drive the slave side shortly after the edge
	always begin
		@(posedge clk);
		#10;
		if (wb_cyc !== 1'b1) begin
			wb_ack = 1'b0;
			in_acc = 1'b0;
		end else begin
			if (!in_acc) begin
				in_acc = 1'b1;
				waits_left = (cur_maxw == 0) ? 0 : {$random(seed)} % (cur_maxw + 1);
			end
			if (waits_left == 0) begin
				wb_ack = 1'b1;
				if (wb_adr > 16'h00FF && !wb_we)
					note_failure($sformatf("load outside data memory at %h", wb_adr));
				wb_dat_i = wb_we ? 16'h0000 : dmem[wb_adr[7:0]];
			end else begin
				wb_ack = 1'b0;
				waits_left--;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Watchdog, sized from the instruction counts

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [15:0] exp_pc, exp_instr;
		int p, n, nd, ns, err_before;
		rst_n = 1'b0;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		errors = 0;
		failed_tests = 0;
		limit_ns = 0;
		cur_maxw = 0;
		for (int i = 0; i < 256; i++)
			imem[i] = 16'hF000 | i;
		$readmemh("tests/cpu_cases.txt", cases);
		num_tests = cases[0];
		if (num_tests == 0)
			note_failure("cases file holds no tests");
		// Walk the records once for the start points and watchdog size
		p = 1;
		max_wait = 0;
		total_instr = 0;
		for (int t = 0; t < num_tests; t++) begin
			test_start[t] = p;
			if (cases[p] > max_wait)
				max_wait = cases[p];
			n = cases[p + 1];
			total_instr += n;
			p += 2 + n;
			nd = cases[p];
			p += 1 + 2 * nd;
			ns = cases[p];
			p += 2 + 2 * ns;
		end
		limit_ns = total_instr * (max_wait + 4) * 100;
		for (int t = 0; t < num_tests; t++) begin
			err_before = errors;
			stores_seen = 0;
			@(posedge clk);
			#10;
			rst_n = 1'b0;
			load_test(t, exp_pc, exp_instr);
			repeat (3) @(posedge clk);
			#10;
			// Reset state
			check_bit("wb_cyc", wb_cyc, 1'b0);
			check_bit("wb_stb", wb_stb, 1'b0);
			check_bit("wb_we", wb_we, 1'b0);
			check_bit("hlt", hlt, 1'b0);
			check_word("pc", pc, 16'h0000);
			rst_n = 1'b1;
			do begin
				@(posedge clk);
				#10;
			end while (hlt !== 1'b1);
			// Halted core stays put
			repeat (4) begin
				@(posedge clk);
				#10;
				check_bit("hlt", hlt, 1'b1);
				check_word("pc", pc, exp_pc);
				check_word("imem_addr", imem_addr, exp_pc);
			end
			check_instr("imem_data", imem_data, exp_instr);
			if (exp_adr.size() != 0)
				note_failure($sformatf("%0d expected stores never happened", exp_adr.size()));
			if (errors != err_before)
				failed_tests++;
			$display("test %0d finished: %0d stores, %0d errors", t + 1, stores_seen,
				errors - err_before);
		end
		$display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/forward_unit.sv
hdl/hazard_unit.sv
hdl/cpu.sv
tests/tb_clock.sv
tests/cpu_tb.sv

// ==== tests/cpu_cases.txt ====
// Number of tests, then per test: max_wait ninstr program ndata (adr dat)
// nstores (adr dat) expected_final_pc
0005
// 1 arithmetic, logic, shifts, LLB and LHB
0000 0010
B105 B2FD 0312 2413 3534 4614 5762 6871 A812 9806 9301 9402 9503 9604 9705 F000
0000
0006 0006 12F0 0001 0002 0002 0003 0003 0002 0004 FFF8 0005 FFE0
0010
// 2 load followed by dependent use
0000 000A
B108 8210 0322 8411 9410 9312 8510 4652 9613 F000
0002 0008 1234 0009 00FF
0003 0008 00FF 000A 2468 000B ED00
000A
// 3 BEQZ, BNEZ and JR with flushed stores
0000 0010
B100 B203 C102 9200 9201 D101 9202 C201 D201 9203 B30E E030 9204 9205 9306 F000
0000
0002 0002 0003 0006 000E
0010
// 4 same as test 2 with up to three wait states
0003 000A
B108 8210 0322 8411 9410 9312 8510 4652 9613 F000
0002 0008 1234 0009 00FF
0003 0008 00FF 000A 2468 000B ED00
000A
// 5 HLT with stores after it
0000 0005
B107 9100 F000 9101 9102
0000
0001 0000 0007
0003
